/* files.f */
+incdir+tests
hw/ec_pkg.sv
hw/mod_add.sv
hw/mont_mult.sv
hw/ec_add_ctrl.sv
hw/ec_add_datapath.sv
hw/ec_point_adder.sv
tests/tb_ec_point_adder.sv

/* hw/ec_add_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module ec_add_ctrl
    import ec_pkg::*;
(
    input  logic     clk,
    input  logic     resetn,
    input  logic     start,
    input  logic     out_read,
    input  logic     step_done,
    output ec_step_e step,
    output logic     step_start,
    output logic     done
);

    typedef enum logic [1:0] {
        IDLE,
        RUNNING,
        FINISHED
    } state_e;

    state_e state;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= IDLE;
            step       <= STEP_PROD;
            step_start <= 1'b0;
            done       <= 1'b0;
        end else begin
            step_start <= 1'b0;
            case (state)
                IDLE: begin
                    if (start) begin
                        state      <= RUNNING;
                        step       <= STEP_PROD;
                        step_start <= 1'b1;
                    end
                end
                RUNNING: begin
                    if (step_done) begin
                        if (step == STEP_FINAL) begin
                            state <= FINISHED;
                            done  <= 1'b1;
                        end else begin
                            step       <= ec_step_e'(step + 1'b1);
                            step_start <= 1'b1;
                        end
                    end
                end
                FINISHED: begin
                    // Result held until the reader takes it
                    if (out_read) begin
                        state <= IDLE;
                        done  <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_no_done_idle: assert property (
        @(posedge clk) disable iff (!resetn) step_done |-> (state == RUNNING)
    ) else $error("step_done outside a running addition");

endmodule

`default_nettype wire

/* hw/ec_add_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module ec_add_datapath
    import ec_pkg::*;
#(
    parameter field_t MODULUS = BLS12_381_P
) (
    input  logic      clk,
    input  logic      resetn,
    input  ec_step_e  step,
    input  logic      step_start,
    input  ec_point_t p_in,
    input  ec_point_t q_in,
    output logic      step_done,
    output ec_point_t r_out
);

    localparam int N_UNITS = 3;

    // Temporaries, named after the value they hold
    typedef enum logic [5:0] {
        V_T0, V_T1, V_T2, V_XY1, V_XY2, V_YZ1, V_Q, V_YZ2, V_XZ1, V_XZ2,
        V_R, V_W, V_T01, V_T12, V_T02, V_A, V_B, V_C, V_T2X2, V_T0X2,
        V_T2X4, V_H, V_T2X8, V_BC, V_HC, V_HA, V_Z12, V_PP, V_N, V_AN,
        V_PPN, V_BPP, V_BC2, V_HC2, V_BC4, V_HC4, V_BC8, V_HC8, V_BC12, V_HC12,
        V_X3, V_Y3, V_Z3
    } tmp_e;

    typedef struct packed {
        field_t a;
        field_t b;
        tmp_e   dst;
    } mul_op_t;

    typedef struct packed {
        logic   sub;
        field_t a;
        field_t b;
        tmp_e   dst;
    } add_op_t;

    ec_point_t            p_q;
    ec_point_t            q_q;
    field_t               tmp [V_T0:V_Z3];
    mul_op_t              mul_op [N_UNITS];
    add_op_t              add_op [N_UNITS];
    field_t               mul_res [N_UNITS];
    field_t               add_res [N_UNITS];
    logic [N_UNITS-1:0]   use_mul;
    logic [N_UNITS-1:0]   use_add;
    logic [N_UNITS-1:0]   mul_done;
    logic [N_UNITS-1:0]   add_done;
    logic                 step_busy;

    // First step reads the live inputs, which are captured at the same edge
    always_comb begin
        for (int i = 0; i < N_UNITS; i++) begin
            mul_op[i] = '0;
            add_op[i] = '0;
        end
        use_mul = 3'b000;
        use_add = 3'b000;
        case (step)
            STEP_PROD: begin
                use_mul   = 3'b111;
                use_add   = 3'b111;
                mul_op[0] = '{p_in.x, q_in.x, V_T0};
                mul_op[1] = '{p_in.y, q_in.y, V_T1};
                mul_op[2] = '{p_in.z, q_in.z, V_T2};
                add_op[0] = '{1'b0, p_in.x, p_in.y, V_XY1};
                add_op[1] = '{1'b0, q_in.x, q_in.y, V_XY2};
                add_op[2] = '{1'b0, p_in.y, p_in.z, V_YZ1};
            end
            STEP_CROSS1: begin
                use_mul   = 3'b001;
                use_add   = 3'b111;
                mul_op[0] = '{tmp[V_XY1], tmp[V_XY2], V_Q};
                add_op[0] = '{1'b0, q_q.y, q_q.z, V_YZ2};
                add_op[1] = '{1'b0, p_q.x, p_q.z, V_XZ1};
                add_op[2] = '{1'b0, q_q.x, q_q.z, V_XZ2};
            end
            STEP_CROSS2: begin
                use_mul   = 3'b011;
                use_add   = 3'b111;
                mul_op[0] = '{tmp[V_YZ1], tmp[V_YZ2], V_R};
                mul_op[1] = '{tmp[V_XZ1], tmp[V_XZ2], V_W};
                add_op[0] = '{1'b0, tmp[V_T0], tmp[V_T1], V_T01};
                add_op[1] = '{1'b0, tmp[V_T1], tmp[V_T2], V_T12};
                add_op[2] = '{1'b0, tmp[V_T0], tmp[V_T2], V_T02};
            end
            STEP_SUB: begin
                use_add   = 3'b111;
                add_op[0] = '{1'b1, tmp[V_Q], tmp[V_T01], V_A};
                add_op[1] = '{1'b1, tmp[V_R], tmp[V_T12], V_B};
                add_op[2] = '{1'b1, tmp[V_W], tmp[V_T02], V_C};
            end
            STEP_DBL1: begin
                use_add   = 3'b011;
                add_op[0] = '{1'b0, tmp[V_T2], tmp[V_T2], V_T2X2};
                add_op[1] = '{1'b0, tmp[V_T0], tmp[V_T0], V_T0X2};
            end
            STEP_DBL2: begin
                use_add   = 3'b011;
                add_op[0] = '{1'b0, tmp[V_T2X2], tmp[V_T2X2], V_T2X4};
                add_op[1] = '{1'b0, tmp[V_T0X2], tmp[V_T0], V_H};
            end
            STEP_DBL3: begin
                use_mul   = 3'b111;
                use_add   = 3'b001;
                mul_op[0] = '{tmp[V_B], tmp[V_C], V_BC};
                mul_op[1] = '{tmp[V_H], tmp[V_C], V_HC};
                mul_op[2] = '{tmp[V_H], tmp[V_A], V_HA};
                add_op[0] = '{1'b0, tmp[V_T2X4], tmp[V_T2X4], V_T2X8};
            end
            STEP_B12: begin
                // 3b = 12 for this curve
                use_add   = 3'b001;
                add_op[0] = '{1'b0, tmp[V_T2X8], tmp[V_T2X4], V_Z12};
            end
            STEP_PN: begin
                use_add   = 3'b011;
                add_op[0] = '{1'b0, tmp[V_T1], tmp[V_Z12], V_PP};
                add_op[1] = '{1'b1, tmp[V_T1], tmp[V_Z12], V_N};
            end
            STEP_MULT_FINAL: begin
                use_mul   = 3'b111;
                use_add   = 3'b011;
                mul_op[0] = '{tmp[V_A], tmp[V_N], V_AN};
                mul_op[1] = '{tmp[V_PP], tmp[V_N], V_PPN};
                mul_op[2] = '{tmp[V_B], tmp[V_PP], V_BPP};
                add_op[0] = '{1'b0, tmp[V_BC], tmp[V_BC], V_BC2};
                add_op[1] = '{1'b0, tmp[V_HC], tmp[V_HC], V_HC2};
            end
            STEP_X4: begin
                use_add   = 3'b011;
                add_op[0] = '{1'b0, tmp[V_BC2], tmp[V_BC2], V_BC4};
                add_op[1] = '{1'b0, tmp[V_HC2], tmp[V_HC2], V_HC4};
            end
            STEP_X8: begin
                use_add   = 3'b011;
                add_op[0] = '{1'b0, tmp[V_BC4], tmp[V_BC4], V_BC8};
                add_op[1] = '{1'b0, tmp[V_HC4], tmp[V_HC4], V_HC8};
            end
            STEP_X12: begin
                use_add   = 3'b011;
                add_op[0] = '{1'b0, tmp[V_BC8], tmp[V_BC4], V_BC12};
                add_op[1] = '{1'b0, tmp[V_HC8], tmp[V_HC4], V_HC12};
            end
            STEP_FINAL: begin
                use_add   = 3'b111;
                add_op[0] = '{1'b1, tmp[V_AN], tmp[V_BC12], V_X3};
                add_op[1] = '{1'b0, tmp[V_PPN], tmp[V_HC12], V_Y3};
                add_op[2] = '{1'b0, tmp[V_BPP], tmp[V_HA], V_Z3};
            end
            default: begin
                use_mul = 3'b000;
                use_add = 3'b000;
            end
        endcase
    end

    for (genvar i = 0; i < N_UNITS; i++) begin : g_unit
        mont_mult #(
            .MODULUS (MODULUS)
        ) u_mult (
            .clk    (clk),
            .resetn (resetn),
            .start  (step_start & use_mul[i]),
            .a      (mul_op[i].a),
            .b      (mul_op[i].b),
            .result (mul_res[i]),
            .done   (mul_done[i])
        );

        mod_add #(
            .MODULUS (MODULUS)
        ) u_add (
            .clk      (clk),
            .resetn   (resetn),
            .start    (step_start & use_add[i]),
            .subtract (add_op[i].sub),
            .a        (add_op[i].a),
            .b        (add_op[i].b),
            .result   (add_res[i]),
            .done     (add_done[i])
        );
    end

    // Unit done flags are stale on the step_start cycle itself
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            step_busy <= 1'b0;
        end else if (step_start) begin
            step_busy <= 1'b1;
        end else if (step_done) begin
            step_busy <= 1'b0;
        end
    end

    assign step_done = step_busy && (&(mul_done | ~use_mul)) && (&(add_done | ~use_add));

    always_ff @(posedge clk) begin
        if (step_start && step == STEP_PROD) begin
            p_q <= p_in;
            q_q <= q_in;
        end
        if (step_done) begin
            for (int i = 0; i < N_UNITS; i++) begin
                if (use_mul[i]) begin
                    tmp[mul_op[i].dst] <= mul_res[i];
                end
                if (use_add[i]) begin
                    tmp[add_op[i].dst] <= add_res[i];
                end
            end
        end
    end

    assign r_out = '{x: tmp[V_X3], y: tmp[V_Y3], z: tmp[V_Z3]};

endmodule

`default_nettype wire

/* hw/ec_pkg.sv */
`default_nettype none

package ec_pkg;

    localparam int FIELD_W = 381;

    // One field element, kept below the modulus
    typedef logic [FIELD_W-1:0] field_t;

    // Room for a raw sum, a borrow, or the Montgomery accumulator
    typedef logic [FIELD_W+1:0] wide_t;

    // Projective point
    typedef struct packed {
        field_t x;
        field_t y;
        field_t z;
    } ec_point_t;

    localparam field_t BLS12_381_P = field_t'({
        192'h1a0111ea397fe69a4b1ba7b6434bacd764774b84f38512bf,
        192'h6730d2a0f6b0f6241eabfffeb153ffffb9feffffffffaaab
    });

    // Addition steps in execution order
    typedef enum logic [3:0] {
        STEP_PROD,
        STEP_CROSS1,
        STEP_CROSS2,
        STEP_SUB,
        STEP_DBL1,
        STEP_DBL2,
        STEP_DBL3,
        STEP_B12,
        STEP_PN,
        STEP_MULT_FINAL,
        STEP_X4,
        STEP_X8,
        STEP_X12,
        STEP_FINAL
    } ec_step_e;

endpackage

`default_nettype wire

/* hw/ec_point_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module ec_point_adder
    import ec_pkg::*;
#(
    parameter field_t MODULUS = BLS12_381_P
) (
    input  logic      clk,
    input  logic      resetn,
    input  logic      start,
    input  logic      out_read,
    input  ec_point_t p_in,
    input  ec_point_t q_in,
    output ec_point_t r_out,
    output logic      done
);

    ec_step_e step;
    logic     step_start;
    logic     step_done;

    ec_add_ctrl u_ctrl (
        .clk        (clk),
        .resetn     (resetn),
        .start      (start),
        .out_read   (out_read),
        .step_done  (step_done),
        .step       (step),
        .step_start (step_start),
        .done       (done)
    );

    ec_add_datapath #(
        .MODULUS (MODULUS)
    ) u_datapath (
        .clk        (clk),
        .resetn     (resetn),
        .step       (step),
        .step_start (step_start),
        .p_in       (p_in),
        .q_in       (q_in),
        .step_done  (step_done),
        .r_out      (r_out)
    );

endmodule

`default_nettype wire

/* hw/mod_add.sv */
`timescale 1ns/1ps
`default_nettype none

module mod_add
    import ec_pkg::*;
#(
    parameter field_t MODULUS = BLS12_381_P
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   start,
    input  logic   subtract,
    input  field_t a,
    input  field_t b,
    output field_t result,
    output logic   done
);

    wide_t raw;
    wide_t fixed;
    logic  sub_q;
    logic  stage_q;

    // Borrow shows up in the top bit of a negative difference
    assign fixed = sub_q ? (raw[FIELD_W+1] ? raw + wide_t'(MODULUS) : raw)
                         : (raw >= wide_t'(MODULUS) ? raw - wide_t'(MODULUS) : raw);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            stage_q <= 1'b0;
            done    <= 1'b0;
        end else begin
            stage_q <= start;
            if (start) begin
                done <= 1'b0;
            end else if (stage_q) begin
                done <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            sub_q <= subtract;
            raw   <= subtract ? wide_t'(a) - wide_t'(b) : wide_t'(a) + wide_t'(b);
        end
        if (stage_q) begin
            result <= fixed[FIELD_W-1:0];
        end
    end

    a_result_reduced: assert property (
        @(posedge clk) disable iff (!resetn) done |-> (result < MODULUS)
    ) else $error("mod_add result not reduced");

endmodule

`default_nettype wire

/* hw/mont_mult.sv */
`timescale 1ns/1ps
`default_nettype none

module mont_mult
    import ec_pkg::*;
#(
    parameter field_t MODULUS = BLS12_381_P
) (
    input  logic   clk,
    input  logic   resetn,
    input  logic   start,
    input  field_t a,
    input  field_t b,
    output field_t result,
    output logic   done
);

    localparam int CNT_W = $clog2(FIELD_W + 1);

    field_t           a_q;
    field_t           b_q;
    wide_t            acc;
    wide_t            sum_b;
    wide_t            sum_m;
    wide_t            acc_red;
    logic [CNT_W-1:0] cnt;
    logic             busy;
    logic             last;

    // One radix-2 iteration, acc stays below 2*MODULUS
    assign sum_b   = acc + (a_q[0] ? wide_t'(b_q) : '0);
    assign sum_m   = sum_b[0] ? sum_b + wide_t'(MODULUS) : sum_b;
    assign acc_red = (acc >= wide_t'(MODULUS)) ? acc - wide_t'(MODULUS) : acc;
    assign last    = (cnt == CNT_W'(FIELD_W));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy <= 1'b0;
            cnt  <= '0;
            done <= 1'b0;
        end else if (start) begin
            busy <= 1'b1;
            cnt  <= '0;
            done <= 1'b0;
        end else if (busy) begin
            if (last) begin
                busy <= 1'b0;
                done <= 1'b1;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            a_q <= a;
            b_q <= b;
            acc <= '0;
        end else if (busy) begin
            if (last) begin
                // Final conditional subtraction
                result <= acc_red[FIELD_W-1:0];
            end else begin
                acc <= sum_m >> 1;
                a_q <= a_q >> 1;
            end
        end
    end

    a_no_start_busy: assert property (
        @(posedge clk) disable iff (!resetn) start |-> !busy
    ) else $error("mont_mult started while busy");

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f files.f --top-module tb_ec_point_adder

./obj_dir/Vtb_ec_point_adder | tee sim.log

if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

/* tests/ec_ref_model.svh */
`ifndef EC_REF_MODEL_SVH
`define EC_REF_MODEL_SVH

function automatic field_t mod_add_ref(input field_t a, input field_t b);
    wide_t s;
    s = wide_t'(a) + wide_t'(b);
    if (s >= wide_t'(BLS12_381_P)) begin
        s = s - wide_t'(BLS12_381_P);
    end
    return s[FIELD_W-1:0];
endfunction

function automatic field_t mod_sub_ref(input field_t a, input field_t b);
    wide_t s;
    if (a >= b) begin
        s = wide_t'(a) - wide_t'(b);
    end else begin
        s = wide_t'(a) + wide_t'(BLS12_381_P) - wide_t'(b);
    end
    return s[FIELD_W-1:0];
endfunction

// Radix-2 Montgomery product, a*b*2^-381 mod p
function automatic field_t mont_ref(input field_t a, input field_t b);
    wide_t acc;
    acc = '0;
    for (int i = 0; i < FIELD_W; i++) begin
        if (a[i]) begin
            acc = acc + wide_t'(b);
        end
        if (acc[0]) begin
            acc = acc + wide_t'(BLS12_381_P);
        end
        acc = acc >> 1;
    end
    if (acc >= wide_t'(BLS12_381_P)) begin
        acc = acc - wide_t'(BLS12_381_P);
    end
    return acc[FIELD_W-1:0];
endfunction

// Complete addition for a = 0, 3b = 12
function automatic ec_point_t ec_add_ref(input ec_point_t p, input ec_point_t q);
    field_t t0, t1, t2, cq, cr, cw, a, b, c;
    field_t h, t2x4, z12, pp, n, bc, hc, ha, bc4, hc4, bc12, hc12;
    ec_point_t r;
    t0 = mont_ref(p.x, q.x);
    t1 = mont_ref(p.y, q.y);
    t2 = mont_ref(p.z, q.z);
    cq = mont_ref(mod_add_ref(p.x, p.y), mod_add_ref(q.x, q.y));
    cr = mont_ref(mod_add_ref(p.y, p.z), mod_add_ref(q.y, q.z));
    cw = mont_ref(mod_add_ref(p.x, p.z), mod_add_ref(q.x, q.z));
    a = mod_sub_ref(cq, mod_add_ref(t0, t1));
    b = mod_sub_ref(cr, mod_add_ref(t1, t2));
    c = mod_sub_ref(cw, mod_add_ref(t0, t2));
    h = mod_add_ref(mod_add_ref(t0, t0), t0);
    t2x4 = mod_add_ref(mod_add_ref(t2, t2), mod_add_ref(t2, t2));
    z12 = mod_add_ref(mod_add_ref(t2x4, t2x4), t2x4);
    pp = mod_add_ref(t1, z12);
    n = mod_sub_ref(t1, z12);
    bc = mont_ref(b, c);
    hc = mont_ref(h, c);
    ha = mont_ref(h, a);
    bc4 = mod_add_ref(mod_add_ref(bc, bc), mod_add_ref(bc, bc));
    hc4 = mod_add_ref(mod_add_ref(hc, hc), mod_add_ref(hc, hc));
    bc12 = mod_add_ref(mod_add_ref(bc4, bc4), bc4);
    hc12 = mod_add_ref(mod_add_ref(hc4, hc4), hc4);
    r.x = mod_sub_ref(mont_ref(a, n), bc12);
    r.y = mod_add_ref(mont_ref(pp, n), hc12);
    r.z = mod_add_ref(mont_ref(b, pp), ha);
    return r;
endfunction

`endif

/* tests/tb_ec_point_adder.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ec_point_adder
    import ec_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 4000;

    logic      clk;
    logic      resetn;
    logic      start;
    logic      out_read;
    ec_point_t p_in;
    ec_point_t q_in;
    ec_point_t r_out;
    logic      done;

    integer    seed;
    int        mismatches;
    int        failures;
    int        done_rises;
    logic      done_prev;

    `include "ec_ref_model.svh"

    ec_point_adder #(
        .MODULUS (BLS12_381_P)
    ) u_dut (
        .clk      (clk),
        .resetn   (resetn),
        .start    (start),
        .out_read (out_read),
        .p_in     (p_in),
        .q_in     (q_in),
        .r_out    (r_out),
        .done     (done)
    );

    always #2 clk = ~clk;

    // Counts rising edges of done
    always @(posedge clk) begin
        if (!resetn) begin
            done_prev  <= 1'b0;
            done_rises <= 0;
        end else begin
            done_prev <= done;
            if (done && !done_prev) begin
                done_rises <= done_rises + 1;
            end
        end
    end

    task automatic check_point(input string name, input ec_point_t expected,
                               input ec_point_t actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Mismatch %s: expected %b, actual %b", name, expected, actual);
            mismatches++;
        end
    endtask

    task automatic wait_level(input string name, input logic level, input int limit,
                              output bit seen);
        int cycles;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            @(negedge clk);
            seen = (done === level);
            cycles++;
        end
        if (!seen) begin
            $display("%s: done did not go to %b within %0d cycles", name, level, limit);
            failures++;
        end
    endtask

    task automatic random_field(output field_t v);
        logic [383:0] raw;
        raw = '0;
        for (int i = 0; i < 12; i++) begin
            raw = {raw[351:0], 32'($random(seed))};
        end
        v = raw[FIELD_W-1:0];
        while (v >= BLS12_381_P) begin
            v = v - BLS12_381_P;
        end
    endtask

    task automatic random_point(output ec_point_t pt);
        random_field(pt.x);
        random_field(pt.y);
        random_field(pt.z);
    endtask

    // Inputs stay on the bus until the next drive
    task automatic start_add(input ec_point_t p, input ec_point_t q);
        @(posedge clk);
        p_in  <= p;
        q_in  <= q;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic read_result(input string name);
        bit fell;
        @(posedge clk);
        out_read <= 1'b1;
        @(posedge clk);
        out_read <= 1'b0;
        wait_level({name, " after out_read"}, 1'b0, 1, fell);
    endtask

    task automatic run_and_check(input string name, input ec_point_t p, input ec_point_t q);
        bit seen;
        start_add(p, q);
        wait_level(name, 1'b1, TIMEOUT_CYCLES, seen);
        if (seen) begin
            check_point(name, ec_add_ref(p, q), r_out);
        end
        read_result(name);
    endtask

    task automatic test_reset();
        repeat (16) begin
            @(negedge clk);
            check_bit("test_reset in reset", 1'b0, done);
        end
        @(posedge clk);
        resetn <= 1'b1;
        repeat (20) begin
            @(negedge clk);
            check_bit("test_reset after reset", 1'b0, done);
        end
    endtask

    task automatic test_fixed();
        ec_point_t p;
        ec_point_t q;
        p.x = '0;
        p.y = BLS12_381_P - field_t'(1);
        p.z = field_t'(1);
        q.x = BLS12_381_P - field_t'(1);
        q.y = field_t'(5);
        q.z = BLS12_381_P - field_t'(1);
        run_and_check("test_fixed", p, q);
    endtask

    task automatic test_random();
        ec_point_t p;
        ec_point_t q;
        for (int i = 0; i < 8; i++) begin
            random_point(p);
            random_point(q);
            run_and_check($sformatf("test_random %0d", i), p, q);
        end
    endtask

    task automatic test_hold_read();
        ec_point_t p;
        ec_point_t q;
        ec_point_t expected;
        bit        seen;
        random_point(p);
        random_point(q);
        expected = ec_add_ref(p, q);
        start_add(p, q);
        wait_level("test_hold_read", 1'b1, TIMEOUT_CYCLES, seen);
        if (seen) begin
            check_point("test_hold_read", expected, r_out);
            repeat (50) begin
                @(negedge clk);
                check_bit("test_hold_read done held", 1'b1, done);
                check_point("test_hold_read r_out stable", expected, r_out);
            end
        end
        read_result("test_hold_read");
        random_point(p);
        random_point(q);
        run_and_check("test_hold_read second", p, q);
    endtask

    task automatic test_busy_start();
        ec_point_t p1;
        ec_point_t q1;
        ec_point_t p2;
        ec_point_t q2;
        int        rises_before;
        bit        seen;
        random_point(p1);
        random_point(q1);
        random_point(p2);
        random_point(q2);
        rises_before = done_rises;
        start_add(p1, q1);
        repeat (10) @(posedge clk);
        p_in  <= p2;
        q_in  <= q2;
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        wait_level("test_busy_start", 1'b1, TIMEOUT_CYCLES, seen);
        if (seen) begin
            check_point("test_busy_start", ec_add_ref(p1, q1), r_out);
        end
        read_result("test_busy_start");
        // Long enough for a wrongly accepted second addition to finish
        repeat (TIMEOUT_CYCLES) @(negedge clk);
        check_bit("test_busy_start done idle", 1'b0, done);
        if (done_rises - rises_before != 1) begin
            $display("test_busy_start: done rose %0d times instead of once",
                     done_rises - rises_before);
            failures++;
        end
    endtask

    initial begin
        seed       = 57;
        mismatches = 0;
        failures   = 0;
        clk        = 1'b0;
        resetn   <= 1'b0;
        start    <= 1'b0;
        out_read <= 1'b0;
        p_in     <= '0;
        q_in     <= '0;
        test_reset();
        test_fixed();
        test_random();
        test_hold_read();
        test_busy_start();
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
